// ==== hdl/stq_cfg_pkg.sv ====
/*
 Store queue geometry and the basic field types.
 Imported by every store queue block and by the testbench.
*/
package stq_cfg_pkg;

  // queue depth, must stay a power of two so index math wraps on its own
  localparam int stq_entries = 16;
  localparam int stq_idx_w   = $clog2(stq_entries);

  localparam int stq_addr_w  = 30;  // word address
  localparam int stq_data_w  = 32;
  localparam int stq_bytes_w = stq_data_w / 8;

  // entry number
  typedef logic [stq_idx_w-1:0] stq_idx_t;

  // word address, byte offset already stripped
  typedef logic [stq_addr_w-1:0] stq_addr_t;

  typedef logic [stq_data_w-1:0] stq_data_t;

  // one enable per byte lane
  typedef logic [stq_bytes_w-1:0] stq_bytes_t;

endpackage

// ==== hdl/stq_chk_pkg.sv ====
/*
 Load check result encoding and the age helper used by the matchers.
*/
package stq_chk_pkg;
  import stq_cfg_pkg::*;

  typedef enum logic [1:0] {
    CHK_IDLE    = 2'd0,  // no check last cycle
    CHK_MISS    = 2'd1,
    CHK_HIT     = 2'd2,  // data forwarded
    CHK_PARTIAL = 2'd3   // overlap but not forwardable
  } chk_res_e;

  // age relative to the retire head, wraps with the index width
  function automatic stq_idx_t chk_age(stq_idx_t idx, stq_idx_t head);
    return idx - head;
  endfunction

endpackage

// ==== hdl/stq_entry_if.sv ====
/*
 Entry contents, head pointer and free strobe shared by the queue blocks.
 The array owns the entries, the retire unit owns head and free.
*/
`timescale 1ns/1ps

interface stq_entry_if import stq_cfg_pkg::*; ();

  logic [stq_entries-1:0]       valid;
  logic [stq_entries-1:0]       data_ok;  // store data has arrived
  stq_addr_t [stq_entries-1:0]  addr;
  stq_bytes_t [stq_entries-1:0] bytes;
  stq_data_t [stq_entries-1:0]  data;

  stq_idx_t head;     // oldest entry
  logic     free_en;  // release head entry

  modport array (
    output valid,
    output data_ok,
    output addr,
    output bytes,
    output data,
    input  head,
    input  free_en
  );

  modport match (
    input valid,
    input data_ok,
    input addr,
    input bytes,
    input data,
    input head
  );

  modport retire (
    input  valid,
    input  data_ok,
    input  addr,
    input  bytes,
    input  data,
    output head,
    output free_en
  );

endinterface

// ==== hdl/stq_entry_array.sv ====
/*
 Store queue entry storage.
 Address capture, data update and free of the head entry, all registered.
*/
`timescale 1ns/1ps

module stq_entry_array import stq_cfg_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // store address port
  input  logic       wrt_en,
  input  stq_idx_t   wrt_idx,
  input  stq_addr_t  wrt_addr,
  input  stq_bytes_t wrt_bytes,

  // store data port
  input  logic       upd_en,
  input  stq_idx_t   upd_idx,
  input  stq_data_t  upd_data,

  stq_entry_if.array ent
);

  // status flags
  always_ff @(posedge clk) begin
    if (rst) begin
      ent.valid   <= '0;
      ent.data_ok <= '0;
    end else begin
      if (ent.free_en) begin
        ent.valid[ent.head] <= 1'b0;
      end
      if (wrt_en) begin
        ent.valid[wrt_idx]   <= 1'b1;
        ent.data_ok[wrt_idx] <= 1'b0;  // new store, data still pending
      end
      if (upd_en) begin
        ent.data_ok[upd_idx] <= 1'b1;
      end
    end
  end

  // address and byte mask
  always_ff @(posedge clk) begin
    if (wrt_en) begin
      ent.addr[wrt_idx]  <= wrt_addr;
      ent.bytes[wrt_idx] <= wrt_bytes;
    end
  end

  // store data
  always_ff @(posedge clk) begin
    if (upd_en) begin
      ent.data[upd_idx] <= upd_data;
    end
  end

endmodule

// ==== hdl/stq_match.sv ====
/*
 One load check port with store-to-load forwarding.
 Searches all valid entries for the youngest overlapping store, result one cycle later.
*/
`timescale 1ns/1ps

module stq_match import stq_cfg_pkg::*; import stq_chk_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       chk_en,
  input  stq_addr_t  chk_addr,
  input  stq_bytes_t chk_bytes,

  stq_entry_if.match ent,

  output chk_res_e   chk_res,
  output stq_data_t  chk_data
);

  logic [stq_entries-1:0]     ovl;  // same word, some byte in common
  stq_idx_t [stq_entries-1:0] age;

  logic      found;
  stq_idx_t  sel_idx;
  stq_idx_t  sel_age;

  chk_res_e  res_d;
  stq_data_t data_d;

  always_comb begin
    for (int i = 0; i < stq_entries; i++) begin
      ovl[i] = ent.valid[i] && (ent.addr[i] == chk_addr) && |(ent.bytes[i] & chk_bytes);
      age[i] = chk_age(stq_idx_t'(i), ent.head);
    end
  end

  // youngest overlapping store, largest age wins
  always_comb begin
    found   = 1'b0;
    sel_idx = '0;
    sel_age = '0;
    for (int i = 0; i < stq_entries; i++) begin
      if (ovl[i] && (!found || age[i] > sel_age)) begin
        found   = 1'b1;
        sel_idx = stq_idx_t'(i);
        sel_age = age[i];
      end
    end
  end

  always_comb begin
    res_d  = CHK_MISS;
    data_d = '0;
    if (found) begin
      // full cover and data present, else the load has to wait
      if (((ent.bytes[sel_idx] & chk_bytes) == chk_bytes) && ent.data_ok[sel_idx]) begin
        res_d  = CHK_HIT;
        data_d = ent.data[sel_idx];
      end else begin
        res_d = CHK_PARTIAL;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_res <= CHK_IDLE;
    end else if (chk_en) begin
      chk_res <= res_d;
    end else begin
      chk_res <= CHK_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    chk_data <= chk_en ? data_d : '0;
  end

endmodule

// ==== hdl/stq_retire.sv ====
/*
 In-order retirement of the oldest store onto the write-line port.
 Owns the head pointer; a refused retire pulse is simply dropped.
*/
`timescale 1ns/1ps

module stq_retire import stq_cfg_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  input  logic        pse_en,
  input  logic        stall,

  stq_entry_if.retire ent,

  output logic        wln_en,
  output stq_addr_t   wln_addr,
  output stq_bytes_t  wln_bytes,
  output stq_data_t   wln_data
);

  stq_idx_t head_q;
  logic     accept;

  // head must hold a complete store
  assign accept = pse_en && !stall && ent.valid[head_q] && ent.data_ok[head_q];

  assign ent.free_en = accept;
  assign ent.head    = head_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      wln_en <= 1'b0;
    end else begin
      wln_en <= accept;
      if (accept) begin
        head_q <= head_q + stq_idx_t'(1);  // wraps at depth
      end
    end
  end

  // write-line payload
  always_ff @(posedge clk) begin
    if (accept) begin
      wln_addr  <= ent.addr[head_q];
      wln_bytes <= ent.bytes[head_q];
      wln_data  <= ent.data[head_q];
    end
  end

endmodule

// ==== hdl/stq_top.sv ====
/*
 Store queue top level.
 Entry array, two load check ports and the retire unit around one entry interface.
*/
`timescale 1ns/1ps

module stq_top import stq_cfg_pkg::*; import stq_chk_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       wrt_en,
  input  stq_idx_t   wrt_idx,
  input  stq_addr_t  wrt_addr,
  input  stq_bytes_t wrt_bytes,

  input  logic       upd_en,
  input  stq_idx_t   upd_idx,
  input  stq_data_t  upd_data,

  input  logic       chk0_en,
  input  stq_addr_t  chk0_addr,
  input  stq_bytes_t chk0_bytes,
  input  logic       chk1_en,
  input  stq_addr_t  chk1_addr,
  input  stq_bytes_t chk1_bytes,

  input  logic       pse_en,
  input  logic       stall,

  output chk_res_e   chk0_res,
  output chk_res_e   chk1_res,
  output stq_data_t  chk0_data,
  output stq_data_t  chk1_data,
  output logic       do_stall,

  output logic       wln_en,
  output stq_addr_t  wln_addr,
  output stq_bytes_t wln_bytes,
  output stq_data_t  wln_data
);

  stq_entry_if ent ();

  stq_entry_array u_array (
    .clk       (clk),
    .rst       (rst),
    .wrt_en    (wrt_en),
    .wrt_idx   (wrt_idx),
    .wrt_addr  (wrt_addr),
    .wrt_bytes (wrt_bytes),
    .upd_en    (upd_en),
    .upd_idx   (upd_idx),
    .upd_data  (upd_data),
    .ent       (ent.array)
  );

  stq_match u_chk0 (
    .clk       (clk),
    .rst       (rst),
    .chk_en    (chk0_en),
    .chk_addr  (chk0_addr),
    .chk_bytes (chk0_bytes),
    .ent       (ent.match),
    .chk_res   (chk0_res),
    .chk_data  (chk0_data)
  );

  stq_match u_chk1 (
    .clk       (clk),
    .rst       (rst),
    .chk_en    (chk1_en),
    .chk_addr  (chk1_addr),
    .chk_bytes (chk1_bytes),
    .ent       (ent.match),
    .chk_res   (chk1_res),
    .chk_data  (chk1_data)
  );

  stq_retire u_retire (
    .clk       (clk),
    .rst       (rst),
    .pse_en    (pse_en),
    .stall     (stall),
    .ent       (ent.retire),
    .wln_en    (wln_en),
    .wln_addr  (wln_addr),
    .wln_bytes (wln_bytes),
    .wln_data  (wln_data)
  );

  // any partial load holds the pipe
  assign do_stall = (chk0_res == CHK_PARTIAL) || (chk1_res == CHK_PARTIAL);

endmodule

// ==== sim/stq_tb.sv ====
/*
 Store queue testbench with a cycle model of the queue.
 Runs directed tests and a random mix and compares model and DUT every cycle.
*/
`timescale 1ns/1ps

module stq_tb import stq_cfg_pkg::*; import stq_chk_pkg::*; ();

  localparam int rst_cycles = 16;
  localparam int dir_cycles = 63;  // directed tests and the closing drain
  localparam int rnd_cycles = 300;
  localparam int run_limit  = rst_cycles + dir_cycles + rnd_cycles + 200;

  logic       clk;
  logic       rst;
  logic       wrt_en, upd_en, chk0_en, chk1_en, pse_en, stall;
  stq_idx_t   wrt_idx, upd_idx;
  stq_addr_t  wrt_addr, chk0_addr, chk1_addr;
  stq_bytes_t wrt_bytes, chk0_bytes, chk1_bytes;
  stq_data_t  upd_data;
  chk_res_e   chk0_res, chk1_res;
  stq_data_t  chk0_data, chk1_data;
  logic       do_stall, wln_en;
  stq_addr_t  wln_addr;
  stq_bytes_t wln_bytes;
  stq_data_t  wln_data;

  // queue model
  logic [stq_entries-1:0] m_valid;
  logic [stq_entries-1:0] m_dok;
  stq_addr_t  m_addr [stq_entries];
  stq_bytes_t m_bytes [stq_entries];
  stq_data_t  m_data [stq_entries];
  stq_idx_t   m_head;

  // what the DUT should show this cycle
  chk_res_e   e_res0, e_res1;
  stq_data_t  e_data0, e_data1;
  logic       e_wln;
  stq_addr_t  e_waddr;
  stq_bytes_t e_wbytes;
  stq_data_t  e_wdata;

  int       n_pass;
  int       n_fail;
  int       fail_mark;
  integer   seed;
  stq_idx_t tail;  // next entry to allocate

  stq_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    n_fail++;
    $display("** Error [%0t] %s", $time, msg);
  endtask

  function automatic void predict(input logic en, input stq_addr_t a, input stq_bytes_t b,
                                  output chk_res_e res, output stq_data_t d);
    stq_idx_t idx;
    stq_idx_t sel;
    logic     found;
    found = 1'b0;
    sel   = '0;
    d     = '0;
    // walk oldest to youngest so the last overlap wins
    for (int k = 0; k < stq_entries; k++) begin
      idx = m_head + stq_idx_t'(k);
      if (m_valid[idx] && m_addr[idx] == a && (m_bytes[idx] & b) != '0) begin
        found = 1'b1;
        sel   = idx;
      end
    end
    if (!en) begin
      res = CHK_IDLE;
    end else if (!found) begin
      res = CHK_MISS;
    end else if ((b & ~m_bytes[sel]) == '0 && m_dok[sel]) begin
      res = CHK_HIT;
      d   = m_data[sel];
    end else begin
      res = CHK_PARTIAL;
    end
  endfunction

  always @(posedge clk) begin : model
    chk_res_e  r0, r1;
    stq_data_t d0, d1;
    logic      acc;
    predict(chk0_en, chk0_addr, chk0_bytes, r0, d0);
    predict(chk1_en, chk1_addr, chk1_bytes, r1, d1);
    acc = pse_en && !stall && m_valid[m_head] && m_dok[m_head];
    if (rst) begin
      m_valid <= '0;
      m_dok   <= '0;
      m_head  <= '0;
      e_res0  <= CHK_IDLE;
      e_res1  <= CHK_IDLE;
      e_data0 <= '0;
      e_data1 <= '0;
      e_wln   <= 1'b0;
    end else begin
      e_res0  <= r0;
      e_res1  <= r1;
      e_data0 <= d0;
      e_data1 <= d1;
      e_wln   <= acc;
      if (acc) begin
        e_waddr         <= m_addr[m_head];
        e_wbytes        <= m_bytes[m_head];
        e_wdata         <= m_data[m_head];
        m_valid[m_head] <= 1'b0;
        m_head          <= m_head + 1'b1;
      end
      if (wrt_en) begin
        m_valid[wrt_idx] <= 1'b1;
        m_dok[wrt_idx]   <= 1'b0;
        m_addr[wrt_idx]  <= wrt_addr;
        m_bytes[wrt_idx] <= wrt_bytes;
      end
      if (upd_en) begin
        m_dok[upd_idx]  <= 1'b1;
        m_data[upd_idx] <= upd_data;
      end
    end
  end

  // compare at mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (!rst) begin
      assert (chk0_res == e_res0 && chk0_data == e_data0) n_pass++;
      else report_mismatch($sformatf("port 0 gave %s %h, expected %s %h",
                                     chk0_res.name(), chk0_data, e_res0.name(), e_data0));
      assert (chk1_res == e_res1 && chk1_data == e_data1) n_pass++;
      else report_mismatch($sformatf("port 1 gave %s %h, expected %s %h",
                                     chk1_res.name(), chk1_data, e_res1.name(), e_data1));
      assert (do_stall == (e_res0 == CHK_PARTIAL || e_res1 == CHK_PARTIAL)) n_pass++;
      else report_mismatch($sformatf("do_stall is %b", do_stall));
      assert (wln_en == e_wln && (!e_wln || {wln_addr, wln_bytes, wln_data} ==
                                            {e_waddr, e_wbytes, e_wdata})) n_pass++;
      else report_mismatch($sformatf("write line %b %h %h %h, expected %b %h %h %h",
                                     wln_en, wln_addr, wln_bytes, wln_data,
                                     e_wln, e_waddr, e_wbytes, e_wdata));
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
    {wrt_en, upd_en, chk0_en, chk1_en, pse_en} = '0;
  endtask

  task automatic store_addr(input stq_addr_t a, input stq_bytes_t b);
    wrt_en    = 1'b1;
    wrt_idx   = tail;
    wrt_addr  = a;
    wrt_bytes = b;
    tail      = tail + 1'b1;
    tick();
  endtask

  task automatic store_data(input stq_idx_t idx, input stq_data_t d);
    upd_en   = 1'b1;
    upd_idx  = idx;
    upd_data = d;
    tick();
  endtask

  // a port expected to stay idle is not enabled
  task automatic load_check(input stq_addr_t a0, input stq_bytes_t b0, input chk_res_e w0,
                            input stq_addr_t a1, input stq_bytes_t b1, input chk_res_e w1);
    chk0_en    = (w0 != CHK_IDLE);
    chk0_addr  = a0;
    chk0_bytes = b0;
    chk1_en    = (w1 != CHK_IDLE);
    chk1_addr  = a1;
    chk1_bytes = b1;
    tick();
    assert (chk0_res == w0 && chk1_res == w1) n_pass++;
    else report_mismatch($sformatf("load gave %s and %s, expected %s and %s",
                                   chk0_res.name(), chk1_res.name(), w0.name(), w1.name()));
  endtask

  task automatic retire_pulse(input logic want);
    pse_en = 1'b1;
    tick();
    assert (wln_en == want) n_pass++;
    else report_mismatch($sformatf("retire gave wln_en %b, expected %b", wln_en, want));
  endtask

  task automatic test_done(input string name);
    $display("%-9s done, %0d errors", name, n_fail - fail_mark);
    fail_mark = n_fail;
  endtask

  task automatic random_mix();
    logic [31:0] r;
    for (int c = 0; c < rnd_cycles; c++) begin
      r = $random(seed);
      if (r[0] && !m_valid[tail]) begin  // allocate only into a free tail
        wrt_en    = 1'b1;
        wrt_idx   = tail;
        wrt_addr  = {28'h0abcdef, r[3:2]};
        wrt_bytes = (r[7:4] != 4'h0) ? r[7:4] : 4'hf;
        tail      = tail + 1'b1;
      end
      if (r[1]) begin
        upd_en   = 1'b1;
        upd_idx  = r[12] ? m_head + stq_idx_t'(r[11:10]) : tail - 1'b1 - stq_idx_t'(r[11:10]);
        upd_data = $random(seed);
      end
      chk0_en    = r[14];
      chk0_addr  = {28'h0abcdef, r[16:15]};
      chk0_bytes = (r[20:17] != 4'h0) ? r[20:17] : 4'hf;
      chk1_en    = r[21];
      chk1_addr  = {28'h0abcdef, r[23:22]};
      chk1_bytes = (r[27:24] != 4'h0) ? r[27:24] : 4'hf;
      pse_en     = r[28];
      stall      = r[29] && r[30];
      tick();
    end
    stall = 1'b0;
  endtask

  initial begin
    seed      = 32'h33cf;
    n_pass    = 0;
    n_fail    = 0;
    fail_mark = 0;
    tail      = '0;
    rst       = 1'b1;
    {wrt_en, upd_en, chk0_en, chk1_en, pse_en, stall} = '0;
    {wrt_idx, wrt_addr, wrt_bytes, upd_idx, upd_data} = '0;
    {chk0_addr, chk0_bytes, chk1_addr, chk1_bytes} = '0;
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!wln_en && !do_stall && chk0_res == CHK_IDLE && chk1_res == CHK_IDLE) n_pass++;
    else report_mismatch("outputs not idle after reset");
    test_done("reset");

    store_addr(30'h100, 4'hf);
    store_data(4'd0, 32'hcafe_f00d);
    load_check(30'h100, 4'b0011, CHK_HIT, 30'h200, 4'hf, CHK_MISS);
    test_done("forward");

    store_addr(30'h300, 4'hf);
    store_addr(30'h300, 4'b0011);
    store_data(4'd1, 32'h1111_1111);
    store_data(4'd2, 32'h2222_2222);
    load_check(30'h300, 4'b0001, CHK_HIT, 30'h300, 4'b0011, CHK_HIT);
    test_done("youngest");

    load_check(30'h300, 4'hf, CHK_PARTIAL, 30'h0, 4'h0, CHK_IDLE);
    store_addr(30'h500, 4'b1100);
    load_check(30'h500, 4'b0100, CHK_PARTIAL, 30'h500, 4'b1100, CHK_PARTIAL);
    store_data(4'd3, 32'h3333_4444);
    load_check(30'h500, 4'b0100, CHK_HIT, 30'h300, 4'b0011, CHK_HIT);
    test_done("partial");

    stall = 1'b1;
    retire_pulse(1'b0);
    stall = 1'b0;
    repeat (4) retire_pulse(1'b1);
    store_addr(30'h600, 4'hf);
    retire_pulse(1'b0);  // head has no data yet
    store_data(4'd4, 32'h6666_0000);
    retire_pulse(1'b1);
    load_check(30'h100, 4'hf, CHK_MISS, 30'h300, 4'hf, CHK_MISS);
    test_done("retire");

    // walk the head up so two same-word stores straddle the wrap
    for (int i = 0; i < 10; i++) begin
      store_addr(stq_addr_t'(30'h700 + i), 4'hf);
      store_data(tail - 1'b1, 32'h5a00_0000 + i);
    end
    store_addr(30'h800, 4'hf);
    store_addr(30'h800, 4'hf);
    store_data(4'd15, 32'haaaa_0015);
    store_data(4'd0, 32'hbbbb_0000);
    load_check(30'h800, 4'hf, CHK_HIT, 30'h800, 4'b1000, CHK_HIT);
    repeat (12) retire_pulse(1'b1);
    load_check(30'h800, 4'hf, CHK_MISS, 30'h700, 4'hf, CHK_MISS);
    test_done("wrap");

    random_mix();
    test_done("random");

    repeat (2) tick();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (run_limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", run_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/stq_cfg_pkg.sv
hdl/stq_chk_pkg.sv
hdl/stq_entry_if.sv
hdl/stq_entry_array.sv
hdl/stq_match.sv
hdl/stq_retire.sv
hdl/stq_top.sv
sim/stq_tb.sv
